//--- verification/decode_cases.txt
# instr    addr     op rd rs1 rs2 immed   (instr, addr, immed in hex; op, rd, rs1, rs2 decimal)
# op is the position of the operation in op_t, counted from 0; immed is sign-extended
003100B3 00001000 0 1 2 3 00000000
403100B3 00001004 36 1 2 3 00000000
003110B3 00001008 26 1 2 3 00000000
003120B3 0000100C 28 1 2 3 00000000
003130B3 00001010 31 1 2 3 00000000
003140B3 00001014 38 1 2 3 00000000
003150B3 00001018 34 1 2 3 00000000
403150B3 0000101C 32 1 2 3 00000000
003160B3 00001020 22 1 2 3 00000000
01FFFFB3 00001024 2 31 31 31 00000000
FFF30293 00001028 1 5 6 0 FFFFFFFF
7FF12093 0000102C 29 1 2 0 000007FF
80013093 00001030 30 1 2 0 FFFFF800
12314093 00001034 39 1 2 0 00000123
00516093 00001038 23 1 2 0 00000005
FF017093 0000103C 3 1 2 0 FFFFFFF0
00311093 00001040 27 1 2 0 00000003
00415093 00001044 35 1 2 0 00000004
40415093 00001048 33 1 2 0 00000404
FFC18503 0000104C 16 10 3 0 FFFFFFFC
00819503 00001050 18 10 3 0 00000008
0001A503 00001054 21 10 3 0 00000000
7FF1C503 00001058 17 10 3 0 000007FF
8001D503 0000105C 19 10 3 0 FFFFF800
FE410FA3 00001060 24 0 2 4 FFFFFFFF
02411223 00001064 25 0 2 4 00000024
80412023 00001068 37 0 2 4 FFFFF800
00208863 0000106C 5 0 1 2 00000010
FE209EE3 00001070 10 0 1 2 FFFFFFFC
0020C0E3 00001074 8 0 1 2 00000800
8020D063 00001078 6 0 1 2 FFFFF000
7E20EFE3 0000107C 9 0 1 2 00000FFE
0020F463 00001080 7 0 1 2 00000008
123452B7 00001084 20 5 0 0 12345000
80000097 00001088 4 1 0 0 80000000
FFFFF06F 0000108C 14 0 0 0 FFFFFFFE
000012EF 00001090 14 5 0 0 00001000
FF8280E7 00001094 15 1 5 0 FFFFFFF8
0FF0000F 00001098 13 0 0 0 00000000
00000073 0000109C 12 0 0 0 00000000
00100073 000010A0 11 0 0 0 00000000
003100FF 000010A4 40 0 0 0 00000000
023100B3 000010A8 40 0 0 0 00000000
003100B2 000010AC 40 0 0 0 00000000
00000000 000010B0 40 0 0 0 00000000
02311093 000010B4 40 0 0 0 00000000
000000F3 000010B8 40 0 0 0 00000000

//--- files.f
src/riscv_decode_pkg.sv
src/opcode_decoder.sv
src/immediate_generator.sv
src/decode_register.sv
src/instruction_decoder.sv
verification/instruction_decoder_assertions.sv
verification/tb_instruction_decoder.sv

//--- Bender.yml
package:
  name: instruction_decoder

sources:
  - src/riscv_decode_pkg.sv
  - src/opcode_decoder.sv
  - src/immediate_generator.sv
  - src/decode_register.sv
  - src/instruction_decoder.sv
  - target: test
    files:
      - verification/instruction_decoder_assertions.sv
      - verification/tb_instruction_decoder.sv

//--- verification/tb_instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_instruction_decoder
   import riscv_decode_pkg::*;
();

   logic                      clock;
   logic                      reset;
   logic                      fetch_valid;
   logic [xlen-1:0]           fetch_addr;
   logic [xlen-1:0]           fetch_instr;
   logic                      decode_valid;
   logic [seq_width-1:0]      decode_seq;
   logic [xlen-1:0]           decode_addr;
   logic [xlen-1:0]           decode_instr;
   op_t                       decode_op;
   logic [reg_addr_width-1:0] decode_rd;
   logic [reg_addr_width-1:0] decode_rs1;
   logic [reg_addr_width-1:0] decode_rs2;
   logic [xlen-1:0]           decode_immed;

   // one entry per line of the cases file
   logic [xlen-1:0] case_instr[$];
   logic [xlen-1:0] case_addr[$];
   int              case_op[$];
   int              case_rd[$];
   int              case_rs1[$];
   int              case_rs2[$];
   logic [xlen-1:0] case_immed[$];

   integer          seed;
   int              max_wait;
   int              tests_passed;
   int              tests_failed;
   int              test_errors;
   logic [63:0]     expected_seq;

   instruction_decoder i_instruction_decoder (
      .clock        (clock),
      .reset        (reset),
      .fetch_valid  (fetch_valid),
      .fetch_addr   (fetch_addr),
      .fetch_instr  (fetch_instr),
      .decode_valid (decode_valid),
      .decode_seq   (decode_seq),
      .decode_addr  (decode_addr),
      .decode_instr (decode_instr),
      .decode_op    (decode_op),
      .decode_rd    (decode_rd),
      .decode_rs1   (decode_rs1),
      .decode_rs2   (decode_rs2),
      .decode_immed (decode_immed)
   );

   always #2 clock = ~clock;

   task automatic compare_field(input string field, input logic [63:0] actual,
                                input logic [63:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, field, actual, expected);
         test_errors++;
      end
   endtask

   task automatic check_outputs(input int idx, input logic exp_valid, input logic [63:0] exp_seq);
      compare_field("decode_valid", decode_valid, exp_valid);
      compare_field("decode_seq", decode_seq, exp_seq);
      compare_field("decode_addr", decode_addr, case_addr[idx]);
      compare_field("decode_instr", decode_instr, case_instr[idx]);
      compare_field("decode_op", decode_op, case_op[idx]);
      compare_field("decode_rd", decode_rd, case_rd[idx]);
      compare_field("decode_rs1", decode_rs1, case_rs1[idx]);
      compare_field("decode_rs2", decode_rs2, case_rs2[idx]);
      compare_field("decode_immed", decode_immed, case_immed[idx]);
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic load_cases();
      int              fd;
      int              fields;
      string           line;
      logic [xlen-1:0] instr;
      logic [xlen-1:0] addr;
      logic [xlen-1:0] immed;
      int              op_num;
      int              rd;
      int              rs1;
      int              rs2;
      fd = $fopen("verification/decode_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open verification/decode_cases.txt for reading");
         test_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // skip blank and comment lines
         if (line.len() < 8 || line[0] == "#") continue;
         fields = $sscanf(line, "%h %h %d %d %d %d %h", instr, addr, op_num, rd, rs1, rs2, immed);
         if (fields == 7) begin
            case_instr.push_back(instr);
            case_addr.push_back(addr);
            case_op.push_back(op_num);
            case_rd.push_back(rd);
            case_rs1.push_back(rs1);
            case_rs2.push_back(rs2);
            case_immed.push_back(immed);
         end else begin
            $display("cases file has a line that does not parse: %s", line);
            test_errors++;
         end
      end
      $fclose(fd);
      if (case_instr.size() == 0) begin
         $display("cases file holds no instructions");
         test_errors++;
      end
   endtask

   task automatic wait_for_output(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < max_wait) begin
         @(negedge clock);
         fetch_valid = 1'b0;
         if (decode_valid === 1'b1) seen = 1'b1;
         cycles++;
      end
      if (!seen) begin
         $display("timeout: decode_valid did not rise within %0d cycles", max_wait);
         test_errors++;
      end
   endtask

   task automatic check_reset_state();
      repeat (3) begin
         @(negedge clock);
         compare_field("decode_valid", decode_valid, 1'b0);
         compare_field("decode_seq", decode_seq, 64'd0);
      end
      finish_test("reset state");
   endtask

   task automatic run_cases();
      int idx;
      int gap;
      bit seen;
      for (idx = 0; idx < case_instr.size(); idx++) begin
         gap = $unsigned($random(seed)) % 4;
         // payload of the previous item holds while idle
         repeat (gap) begin
            @(negedge clock);
            if (idx > 0) begin
               check_outputs(idx - 1, 1'b0, expected_seq);
            end else begin
               compare_field("decode_valid", decode_valid, 1'b0);
               compare_field("decode_seq", decode_seq, expected_seq);
            end
         end
         // without a gap the next item goes out on the same falling edge
         fetch_valid  = 1'b1;
         fetch_addr   = case_addr[idx];
         fetch_instr  = case_instr[idx];
         expected_seq = expected_seq + 1;
         wait_for_output(seen);
         if (seen) check_outputs(idx, 1'b1, expected_seq);
         finish_test($sformatf("case %0d instr %08h", idx, case_instr[idx]));
      end
   endtask

   task automatic run_back_to_back();
      int          k;
      logic [63:0] first_seq;
      first_seq = expected_seq + 1;
      for (k = 0; k < 3; k++) begin
         @(negedge clock);
         if (k > 0) check_outputs(k - 1, 1'b1, first_seq + k - 1);
         fetch_valid = 1'b1;
         fetch_addr  = case_addr[k];
         fetch_instr = case_instr[k];
      end
      @(negedge clock);
      fetch_valid = 1'b0;
      check_outputs(2, 1'b1, first_seq + 2);
      @(negedge clock);
      check_outputs(2, 1'b0, first_seq + 2);
      expected_seq = first_seq + 2;
      finish_test("back to back");
   endtask

   initial begin
      seed         = 32'h2754_dc8b;
      max_wait     = 8;
      clock        = 1'b0;
      reset        = 1'b1;
      fetch_valid  = 1'b0;
      fetch_addr   = '0;
      fetch_instr  = '0;
      tests_passed = 0;
      tests_failed = 0;
      test_errors  = 0;
      expected_seq = 64'd0;
      load_cases();
      finish_test("load cases");
      repeat (10) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      check_reset_state();
      run_cases();
      if (case_instr.size() >= 3) run_back_to_back();
      $display("tests passed %0d, failed %0d, assertion failures %0d", tests_passed,
               tests_failed, i_instruction_decoder.i_instruction_decoder_assertions.failure_count);
      if (tests_failed == 0 &&
          i_instruction_decoder.i_instruction_decoder_assertions.failure_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule : tb_instruction_decoder

`default_nettype wire

//--- verification/instruction_decoder_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder_assertions
   import riscv_decode_pkg::*;
(
   input wire logic                 clock,
   input wire logic                 reset,
   input wire logic                 fetch_valid,
   input wire logic                 decode_valid,
   input wire logic [seq_width-1:0] decode_seq
);

   int unsigned failure_count = 0;

   // one cycle of latency on the valid strobe
   valid_follows_fetch: assert property (
      @(posedge clock) disable iff (reset)
      !$past(reset) |-> decode_valid == $past(fetch_valid)
   ) else begin
      $error("decode_valid is not fetch_valid delayed by one cycle");
      failure_count++;
   end

   // counts up on each output item, holds otherwise
   seq_counts_items: assert property (
      @(posedge clock) disable iff (reset)
      !$past(reset) |->
         decode_seq == (decode_valid ? $past(decode_seq) + 64'd1 : $past(decode_seq))
   ) else begin
      $error("decode_seq did not step by one per valid output");
      failure_count++;
   end

   valid_low_after_reset: assert property (
      @(posedge clock) reset |=> !decode_valid
   ) else begin
      $error("decode_valid high in the cycle after reset");
      failure_count++;
   end

endmodule : instruction_decoder_assertions

bind instruction_decoder instruction_decoder_assertions i_instruction_decoder_assertions (
   .clock        (clock),
   .reset        (reset),
   .fetch_valid  (fetch_valid),
   .decode_valid (decode_valid),
   .decode_seq   (decode_seq)
);

`default_nettype wire

//--- src/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder
   import riscv_decode_pkg::*;
(
   input  wire logic                      clock,
   input  wire logic                      reset,
   input  wire logic                      fetch_valid,
   input  wire logic [xlen-1:0]           fetch_addr,
   input  wire logic [xlen-1:0]           fetch_instr,
   output logic                           decode_valid,
   output logic      [seq_width-1:0]      decode_seq,
   output logic      [xlen-1:0]           decode_addr,
   output logic      [xlen-1:0]           decode_instr,
   output op_t                            decode_op,
   output logic      [reg_addr_width-1:0] decode_rd,
   output logic      [reg_addr_width-1:0] decode_rs1,
   output logic      [reg_addr_width-1:0] decode_rs2,
   output logic      [xlen-1:0]           decode_immed
);

   op_t                       op;
   imm_format_t               imm_format;
   logic [reg_addr_width-1:0] rd;
   logic [reg_addr_width-1:0] rs1;
   logic [reg_addr_width-1:0] rs2;
   logic [xlen-1:0]           immed;

   // combinational decode of the fetched word
   opcode_decoder i_opcode_decoder (
      .instr      (fetch_instr),
      .op         (op),
      .imm_format (imm_format),
      .rd         (rd),
      .rs1        (rs1),
      .rs2        (rs2)
   );

   immediate_generator i_immediate_generator (
      .instr      (fetch_instr),
      .imm_format (imm_format),
      .immed      (immed)
   );

   // single pipeline stage
   decode_register i_decode_register (
      .clock        (clock),
      .reset        (reset),
      .fetch_valid  (fetch_valid),
      .fetch_addr   (fetch_addr),
      .fetch_instr  (fetch_instr),
      .op           (op),
      .rd           (rd),
      .rs1          (rs1),
      .rs2          (rs2),
      .immed        (immed),
      .decode_valid (decode_valid),
      .decode_seq   (decode_seq),
      .decode_addr  (decode_addr),
      .decode_instr (decode_instr),
      .decode_op    (decode_op),
      .decode_rd    (decode_rd),
      .decode_rs1   (decode_rs1),
      .decode_rs2   (decode_rs2),
      .decode_immed (decode_immed)
   );

endmodule : instruction_decoder

`default_nettype wire

//--- src/decode_register.sv
`timescale 1ns/1ps
`default_nettype none

module decode_register
   import riscv_decode_pkg::*;
(
   input  wire logic                      clock,
   input  wire logic                      reset,
   input  wire logic                      fetch_valid,
   input  wire logic [xlen-1:0]           fetch_addr,
   input  wire logic [xlen-1:0]           fetch_instr,
   input  wire op_t                       op,
   input  wire logic [reg_addr_width-1:0] rd,
   input  wire logic [reg_addr_width-1:0] rs1,
   input  wire logic [reg_addr_width-1:0] rs2,
   input  wire logic [xlen-1:0]           immed,
   output logic                           decode_valid,
   output logic      [seq_width-1:0]      decode_seq,
   output logic      [xlen-1:0]           decode_addr,
   output logic      [xlen-1:0]           decode_instr,
   output op_t                            decode_op,
   output logic      [reg_addr_width-1:0] decode_rd,
   output logic      [reg_addr_width-1:0] decode_rs1,
   output logic      [reg_addr_width-1:0] decode_rs2,
   output logic      [xlen-1:0]           decode_immed
);

   // valid follows fetch by one cycle, sequence counts accepted instructions
   always_ff @(posedge clock) begin
      if (reset) begin
         decode_valid <= 1'b0;
         decode_seq   <= '0;
      end else begin
         decode_valid <= fetch_valid;
         if (fetch_valid) begin
            decode_seq <= decode_seq + 1'b1;
         end
      end
   end

   // payload loads on valid only and holds otherwise
   always_ff @(posedge clock) begin
      if (fetch_valid) begin
         decode_addr  <= fetch_addr;
         decode_instr <= fetch_instr;
         decode_op    <= op;
         decode_rd    <= rd;
         decode_rs1   <= rs1;
         decode_rs2   <= rs2;
         decode_immed <= immed;
      end
   end

endmodule : decode_register

`default_nettype wire

//--- src/immediate_generator.sv
`timescale 1ns/1ps
`default_nettype none

module immediate_generator
   import riscv_decode_pkg::*;
(
   input  wire logic        [xlen-1:0] instr,
   input  wire imm_format_t            imm_format,
   output logic             [xlen-1:0] immed
);

   logic            sign;
   logic [xlen-1:0] immed_i;
   logic [xlen-1:0] immed_s;
   logic [xlen-1:0] immed_b;
   logic [xlen-1:0] immed_u;
   logic [xlen-1:0] immed_j;

   assign sign = instr[xlen-1];

   assign immed_i = {{(xlen-12){sign}}, instr[funct7_msb:funct7_lsb], instr[rs2_msb:rs2_lsb]};
   assign immed_s = {{(xlen-12){sign}}, instr[funct7_msb:funct7_lsb], instr[rd_msb:rd_lsb]};

   // branch offset bits are scattered, bit 0 always zero
   assign immed_b = {
      {(xlen-13){sign}},
      instr[31],
      instr[7],
      instr[30:25],
      instr[11:8],
      1'b0
   };

   assign immed_u = {instr[xlen-1:funct3_lsb], 12'b0};

   assign immed_j = {
      {(xlen-21){sign}},
      instr[31],
      instr[rs1_msb:funct3_lsb],
      instr[20],
      instr[30:21],
      1'b0
   };

   always_comb begin
      case (imm_format)
         fmt_i:   immed = immed_i;
         fmt_s:   immed = immed_s;
         fmt_b:   immed = immed_b;
         fmt_u:   immed = immed_u;
         fmt_j:   immed = immed_j;
         default: immed = '0;
      endcase
   end

endmodule : immediate_generator

`default_nettype wire

//--- src/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder
   import riscv_decode_pkg::*;
(
   input  wire  logic [xlen-1:0]           instr,
   output op_t                             op,
   output imm_format_t                     imm_format,
   output logic       [reg_addr_width-1:0] rd,
   output logic       [reg_addr_width-1:0] rs1,
   output logic       [reg_addr_width-1:0] rs2
);

   major_opcode_t opcode;
   logic [2:0]    funct3;
   logic [6:0]    funct7;
   logic          uses_rd;
   logic          uses_rs1;
   logic          uses_rs2;

   assign opcode = major_opcode_t'(instr[opcode_msb:opcode_lsb]);
   assign funct3 = instr[funct3_msb:funct3_lsb];
   assign funct7 = instr[funct7_msb:funct7_lsb];

   // operation from opcode, then funct3 and funct7
   always_comb begin
      op = op_illegal;
      case (opcode)
         opc_lui:   op = op_lui;
         opc_auipc: op = op_auipc;
         opc_jal:   op = op_jal;
         opc_jalr: begin
            if (funct3 == 3'b000) op = op_jalr;
         end
         opc_branch: begin
            case (funct3)
               3'b000:  op = op_beq;
               3'b001:  op = op_bne;
               3'b100:  op = op_blt;
               3'b101:  op = op_bge;
               3'b110:  op = op_bltu;
               3'b111:  op = op_bgeu;
               default: op = op_illegal;
            endcase
         end
         opc_load: begin
            case (funct3)
               3'b000:  op = op_lb;
               3'b001:  op = op_lh;
               3'b010:  op = op_lw;
               3'b100:  op = op_lbu;
               3'b101:  op = op_lhu;
               default: op = op_illegal;
            endcase
         end
         opc_store: begin
            case (funct3)
               3'b000:  op = op_sb;
               3'b001:  op = op_sh;
               3'b010:  op = op_sw;
               default: op = op_illegal;
            endcase
         end
         opc_imm: begin
            case (funct3)
               3'b000: op = op_addi;
               3'b010: op = op_slti;
               3'b011: op = op_sltiu;
               3'b100: op = op_xori;
               3'b110: op = op_ori;
               3'b111: op = op_andi;
               // shifts keep a funct7 in the upper immediate bits
               3'b001: begin
                  if (funct7 == funct7_base) op = op_slli;
               end
               default: begin
                  if (funct7 == funct7_base) op = op_srli;
                  else if (funct7 == funct7_alt) op = op_srai;
               end
            endcase
         end
         opc_reg: begin
            if (funct7 == funct7_base) begin
               case (funct3)
                  3'b000:  op = op_add;
                  3'b001:  op = op_sll;
                  3'b010:  op = op_slt;
                  3'b011:  op = op_sltu;
                  3'b100:  op = op_xor;
                  3'b101:  op = op_srl;
                  3'b110:  op = op_or;
                  default: op = op_and;
               endcase
            end else if (funct7 == funct7_alt) begin
               if (funct3 == 3'b000) op = op_sub;
               else if (funct3 == 3'b101) op = op_sra;
            end
         end
         opc_misc_mem: begin
            if (funct3 == 3'b000) op = op_fence;
         end
         opc_system: begin
            // everything but the 12-bit function must be zero
            if (instr[rs1_msb:rd_lsb] == '0) begin
               if (instr[funct7_msb:rs2_lsb] == 12'h000) op = op_ecall;
               else if (instr[funct7_msb:rs2_lsb] == 12'h001) op = op_ebreak;
            end
         end
         default: op = op_illegal;
      endcase
   end

   // immediate format and register usage per operation
   always_comb begin
      imm_format = fmt_none;
      uses_rd    = 1'b1;
      uses_rs1   = 1'b1;
      uses_rs2   = 1'b0;
      case (op)
         op_lui, op_auipc: begin
            imm_format = fmt_u;
            uses_rs1   = 1'b0;
         end
         op_jal: begin
            imm_format = fmt_j;
            uses_rs1   = 1'b0;
         end
         op_jalr, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_addi, op_slti, op_sltiu,
         op_xori, op_ori, op_andi, op_slli, op_srli, op_srai: begin
            imm_format = fmt_i;
         end
         op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
            imm_format = fmt_b;
            uses_rd    = 1'b0;
            uses_rs2   = 1'b1;
         end
         op_sb, op_sh, op_sw: begin
            imm_format = fmt_s;
            uses_rd    = 1'b0;
            uses_rs2   = 1'b1;
         end
         op_fence, op_ecall, op_ebreak, op_illegal: begin
            uses_rd  = 1'b0;
            uses_rs1 = 1'b0;
         end
         default: begin
            // register-register alu
            uses_rs2 = 1'b1;
         end
      endcase
   end

   assign rd  = uses_rd  ? instr[rd_msb:rd_lsb]   : '0;
   assign rs1 = uses_rs1 ? instr[rs1_msb:rs1_lsb] : '0;
   assign rs2 = uses_rs2 ? instr[rs2_msb:rs2_lsb] : '0;

endmodule : opcode_decoder

`default_nettype wire

//--- src/riscv_decode_pkg.sv
`default_nettype none

package riscv_decode_pkg;

   localparam int unsigned xlen           = 32;
   localparam int unsigned reg_addr_width = 5;
   localparam int unsigned seq_width      = 64;

   // instruction field positions
   localparam int unsigned opcode_lsb = 0;
   localparam int unsigned opcode_msb = 6;
   localparam int unsigned rd_lsb     = 7;
   localparam int unsigned rd_msb     = 11;
   localparam int unsigned funct3_lsb = 12;
   localparam int unsigned funct3_msb = 14;
   localparam int unsigned rs1_lsb    = 15;
   localparam int unsigned rs1_msb    = 19;
   localparam int unsigned rs2_lsb    = 20;
   localparam int unsigned rs2_msb    = 24;
   localparam int unsigned funct7_lsb = 25;
   localparam int unsigned funct7_msb = 31;

   // funct7 values of the base set
   localparam logic [6:0] funct7_base = 7'b0000000;
   localparam logic [6:0] funct7_alt  = 7'b0100000;

   // major opcodes, prefixed opc_ so they stay apart from op_t
   typedef enum logic [6:0] {
      opc_lui      = 7'b0110111,
      opc_auipc    = 7'b0010111,
      opc_jal      = 7'b1101111,
      opc_jalr     = 7'b1100111,
      opc_branch   = 7'b1100011,
      opc_load     = 7'b0000011,
      opc_store    = 7'b0100011,
      opc_imm      = 7'b0010011,
      opc_reg      = 7'b0110011,
      opc_misc_mem = 7'b0001111,
      opc_system   = 7'b1110011
   } major_opcode_t;

   typedef enum logic [2:0] {
      fmt_none,
      fmt_i,
      fmt_s,
      fmt_b,
      fmt_u,
      fmt_j
   } imm_format_t;

   // numbered from 0 in this order; the cases file depends on it
   typedef enum logic [5:0] {
      op_add,
      op_addi,
      op_and,
      op_andi,
      op_auipc,
      op_beq,
      op_bge,
      op_bgeu,
      op_blt,
      op_bltu,
      op_bne,
      op_ebreak,
      op_ecall,
      op_fence,
      op_jal,
      op_jalr,
      op_lb,
      op_lbu,
      op_lh,
      op_lhu,
      op_lui,
      op_lw,
      op_or,
      op_ori,
      op_sb,
      op_sh,
      op_sll,
      op_slli,
      op_slt,
      op_slti,
      op_sltiu,
      op_sltu,
      op_sra,
      op_srai,
      op_srl,
      op_srli,
      op_sub,
      op_sw,
      op_xor,
      op_xori,
      op_illegal
   } op_t;

endpackage : riscv_decode_pkg

`default_nettype wire
